/* source/rs_alu_pkg.sv */
package rs_alu_pkg;

  localparam int DATA_W      = 32;
  localparam int ADDR_W      = 32;
  localparam int RRF_SEL     = 6;  // Rename register tag
  localparam int SPECTAG_LEN = 5;  // One-hot branch tag
  localparam int ALU_OP_W    = 4;
  localparam int SRC_SEL_W   = 2;

  typedef logic [DATA_W-1:0]      data_t;
  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [RRF_SEL-1:0]     rrf_tag_t;
  typedef logic [SPECTAG_LEN-1:0] spec_tag_t;
  typedef logic [ALU_OP_W-1:0]    alu_op_t;
  typedef logic [SRC_SEL_W-1:0]   src_sel_t;

  // Static part of an entry, fixed at allocation
  typedef struct packed {
    addr_t     pc;
    data_t     imm;
    rrf_tag_t  rrftag;
    logic      dstval;
    src_sel_t  src_a;
    src_sel_t  src_b;
    alu_op_t   alu_op;
    spec_tag_t spectag;
  } rs_payload_t;

  // Value when valid, else rename tag in the low bits
  typedef struct packed {
    logic  valid;
    data_t val;
  } operand_t;

  typedef struct packed {
    rs_payload_t payload;
    operand_t    src1;
    operand_t    src2;
  } alloc_t;

  typedef struct packed {
    data_t src1;
    data_t src2;
  } operand_pair_t;

  typedef struct packed {
    data_t    data;
    rrf_tag_t dst;
    logic     kill;  // Result from a squashed path
  } result_bus_t;

endpackage

/* source/alloc_decode.sv */
module alloc_decode
  import rs_alu_pkg::*;
#(
  parameter int ENT_NUM = 8,
  localparam int ENT_SEL = $clog2(ENT_NUM)
) (
  input  logic               we1,
  input  logic               we2,
  input  logic [ENT_SEL-1:0] waddr1,
  input  logic [ENT_SEL-1:0] waddr2,
  input  alloc_t             alloc1,
  input  alloc_t             alloc2,
  output logic [ENT_NUM-1:0] ent_we,
  output alloc_t             ent_wdata [ENT_NUM]
);

  for (genvar i = 0; i < ENT_NUM; i++) begin : g_ent
    logic hit1;
    logic hit2;

    assign hit1 = we1 && (waddr1 == ENT_SEL'(i));
    assign hit2 = we2 && (waddr2 == ENT_SEL'(i));

    assign ent_we[i]    = hit1 | hit2;
    assign ent_wdata[i] = hit1 ? alloc1 : alloc2;  // Port 1 has priority
  end

  // Both ports landing on one entry would lose an instruction
  assert final (!(we1 && we2) || (waddr1 != waddr2))
    else $error("alloc_decode: both ports allocate entry %0d", waddr1);

endmodule

/* source/operand_wakeup.sv */
module operand_wakeup
  import rs_alu_pkg::*;
#(
  parameter int NUM_RESULT = 5
) (
  input  operand_t    opr,
  input  result_bus_t results [NUM_RESULT],
  output operand_t    next_opr
);

  always_comb begin
    next_opr = opr;
    if (!opr.valid) begin
      for (int i = 0; i < NUM_RESULT; i++) begin
        // Killed results never wake anything
        if (!results[i].kill && (results[i].dst == opr.val[RRF_SEL-1:0])) begin
          next_opr.val   = results[i].data;
          next_opr.valid = 1'b1;
        end
      end
    end
  end

endmodule

/* source/rs_entry.sv */
module rs_entry
  import rs_alu_pkg::*;
#(
  parameter int NUM_RESULT = 5
) (
  input  logic          clk,
  input  logic          reset,
  input  logic          we,
  input  alloc_t        wdata,
  input  result_bus_t   results [NUM_RESULT],
  output rs_payload_t   payload,
  output operand_pair_t operands,
  output logic          valid1,
  output logic          valid2
);

  data_t    src1;
  data_t    src2;
  operand_t opr1;
  operand_t opr2;
  operand_t next_opr1;
  operand_t next_opr2;

  assign opr1 = '{valid: valid1, val: src1};
  assign opr2 = '{valid: valid2, val: src2};

  operand_wakeup #(
    .NUM_RESULT(NUM_RESULT)
  ) i_wakeup1 (
    .opr     (opr1),
    .results (results),
    .next_opr(next_opr1)
  );

  operand_wakeup #(
    .NUM_RESULT(NUM_RESULT)
  ) i_wakeup2 (
    .opr     (opr2),
    .results (results),
    .next_opr(next_opr2)
  );

  // Value woken this cycle goes straight out
  assign operands.src1 = next_opr1.val;
  assign operands.src2 = next_opr2.val;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid1 <= 1'b0;
      valid2 <= 1'b0;
    end else if (we) begin
      valid1 <= wdata.src1.valid;
      valid2 <= wdata.src2.valid;
    end else begin
      valid1 <= next_opr1.valid;
      valid2 <= next_opr2.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      payload <= wdata.payload;
      src1    <= wdata.src1.val;
      src2    <= wdata.src2.val;
    end else begin
      src1 <= next_opr1.val;  // Tag stays until wakeup
      src2 <= next_opr2.val;
    end
  end

endmodule

/* source/busy_tracker.sv */
module busy_tracker
  import rs_alu_pkg::*;
#(
  parameter int ENT_NUM = 8,
  localparam int ENT_SEL = $clog2(ENT_NUM)
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               we1,
  input  logic               we2,
  input  logic [ENT_SEL-1:0] waddr1,
  input  logic [ENT_SEL-1:0] waddr2,
  input  logic               clearbusy,
  input  logic [ENT_SEL-1:0] issueaddr,
  input  logic               prmiss,
  input  spec_tag_t          specfixtag,
  input  spec_tag_t          spectags [ENT_NUM],
  output logic [ENT_NUM-1:0] busyvec
);

  logic [ENT_NUM-1:0] survive;

  // Entries not under the mispredicted branch
  always_comb begin
    for (int i = 0; i < ENT_NUM; i++) begin
      survive[i] = (spectags[i] & specfixtag) == '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busyvec <= '0;
    end else if (prmiss) begin
      busyvec <= busyvec & survive;  // New allocations dropped too
    end else begin
      if (we1) busyvec[waddr1] <= 1'b1;
      if (we2) busyvec[waddr2] <= 1'b1;
      if (clearbusy) busyvec[issueaddr] <= 1'b0;
    end
  end

  // Scheduler may only issue from an occupied entry
  assert property (@(posedge clk) disable iff (reset) clearbusy |-> busyvec[issueaddr])
    else $error("busy_tracker: issue from idle entry %0d", issueaddr);

endmodule

/* source/issue_read.sv */
module issue_read #(
  parameter type payload_t = logic,
  parameter int ENT_NUM = 8,
  localparam int ENT_SEL = $clog2(ENT_NUM)
) (
  input  payload_t           entries [ENT_NUM],
  input  logic [ENT_SEL-1:0] issueaddr,
  output payload_t           selected
);

  always_comb begin
    selected = '0;
    for (int i = 0; i < ENT_NUM; i++) begin
      if (issueaddr == ENT_SEL'(i)) begin
        selected = entries[i];
      end
    end
  end

endmodule

/* source/rs_alu.sv */
module rs_alu
  import rs_alu_pkg::*;
#(
  parameter int ENT_NUM = 8,
  parameter int NUM_RESULT = 5,
  localparam int ENT_SEL = $clog2(ENT_NUM)
) (
  input  logic               clk,
  input  logic               reset,
  // Allocation port 1
  input  logic               we1,
  input  logic [ENT_SEL-1:0] waddr1,
  input  addr_t              wpc_1,
  input  data_t              wimm_1,
  input  rrf_tag_t           wrrftag_1,
  input  logic               wdstval_1,
  input  src_sel_t           wsrc_a_1,
  input  src_sel_t           wsrc_b_1,
  input  alu_op_t            walu_op_1,
  input  spec_tag_t          wspectag_1,
  input  data_t              wsrc1_1,
  input  logic               wvalid1_1,
  input  data_t              wsrc2_1,
  input  logic               wvalid2_1,
  // Allocation port 2
  input  logic               we2,
  input  logic [ENT_SEL-1:0] waddr2,
  input  addr_t              wpc_2,
  input  data_t              wimm_2,
  input  rrf_tag_t           wrrftag_2,
  input  logic               wdstval_2,
  input  src_sel_t           wsrc_a_2,
  input  src_sel_t           wsrc_b_2,
  input  alu_op_t            walu_op_2,
  input  spec_tag_t          wspectag_2,
  input  data_t              wsrc1_2,
  input  logic               wvalid1_2,
  input  data_t              wsrc2_2,
  input  logic               wvalid2_2,
  input  logic               clearbusy,
  input  logic [ENT_SEL-1:0] issueaddr,
  input  logic               prmiss,
  input  spec_tag_t          specfixtag,
  input  data_t              exrslt [NUM_RESULT],
  input  rrf_tag_t           exdst [NUM_RESULT],
  input  logic               kill_spec [NUM_RESULT],
  output logic [ENT_NUM-1:0] busyvec,
  output logic [ENT_NUM-1:0] ready,
  output addr_t              pc,
  output data_t              imm,
  output rrf_tag_t           rrftag,
  output logic               dstval,
  output src_sel_t           src_a,
  output src_sel_t           src_b,
  output alu_op_t            alu_op,
  output spec_tag_t          spectag,
  output data_t              ex_src1,
  output data_t              ex_src2
);

  alloc_t             alloc1;
  alloc_t             alloc2;
  result_bus_t        results [NUM_RESULT];
  logic [ENT_NUM-1:0] ent_we;
  alloc_t             ent_wdata [ENT_NUM];
  rs_payload_t        payloads [ENT_NUM];
  operand_pair_t      oprs [ENT_NUM];
  spec_tag_t          spectags [ENT_NUM];
  logic [ENT_NUM-1:0] valid1;
  logic [ENT_NUM-1:0] valid2;
  rs_payload_t        issue_payload;
  operand_pair_t      issue_oprs;

  assign alloc1 = '{
    payload: '{pc: wpc_1, imm: wimm_1, rrftag: wrrftag_1, dstval: wdstval_1, src_a: wsrc_a_1,
               src_b: wsrc_b_1, alu_op: walu_op_1, spectag: wspectag_1},
    src1: '{valid: wvalid1_1, val: wsrc1_1},
    src2: '{valid: wvalid2_1, val: wsrc2_1}
  };
  assign alloc2 = '{
    payload: '{pc: wpc_2, imm: wimm_2, rrftag: wrrftag_2, dstval: wdstval_2, src_a: wsrc_a_2,
               src_b: wsrc_b_2, alu_op: walu_op_2, spectag: wspectag_2},
    src1: '{valid: wvalid1_2, val: wsrc1_2},
    src2: '{valid: wvalid2_2, val: wsrc2_2}
  };

  for (genvar r = 0; r < NUM_RESULT; r++) begin : g_bus
    assign results[r] = '{data: exrslt[r], dst: exdst[r], kill: kill_spec[r]};
  end

  // Entry writes blocked during a branch miss
  alloc_decode #(
    .ENT_NUM(ENT_NUM)
  ) i_alloc_decode (
    .we1      (we1 & ~prmiss),
    .we2      (we2 & ~prmiss),
    .waddr1   (waddr1),
    .waddr2   (waddr2),
    .alloc1   (alloc1),
    .alloc2   (alloc2),
    .ent_we   (ent_we),
    .ent_wdata(ent_wdata)
  );

  for (genvar i = 0; i < ENT_NUM; i++) begin : g_ent
    rs_entry #(
      .NUM_RESULT(NUM_RESULT)
    ) i_entry (
      .clk     (clk),
      .reset   (reset),
      .we      (ent_we[i]),
      .wdata   (ent_wdata[i]),
      .results (results),
      .payload (payloads[i]),
      .operands(oprs[i]),
      .valid1  (valid1[i]),
      .valid2  (valid2[i])
    );
    assign spectags[i] = payloads[i].spectag;
  end

  busy_tracker #(
    .ENT_NUM(ENT_NUM)
  ) i_busy_tracker (
    .clk       (clk),
    .reset     (reset),
    .we1       (we1),
    .we2       (we2),
    .waddr1    (waddr1),
    .waddr2    (waddr2),
    .clearbusy (clearbusy),
    .issueaddr (issueaddr),
    .prmiss    (prmiss),
    .specfixtag(specfixtag),
    .spectags  (spectags),
    .busyvec   (busyvec)
  );

  assign ready = busyvec & valid1 & valid2;  // Stored flags only, bypass not counted

  issue_read #(
    .payload_t(rs_payload_t),
    .ENT_NUM  (ENT_NUM)
  ) i_issue_payload (
    .entries  (payloads),
    .issueaddr(issueaddr),
    .selected (issue_payload)
  );

  issue_read #(
    .payload_t(operand_pair_t),
    .ENT_NUM  (ENT_NUM)
  ) i_issue_operands (
    .entries  (oprs),
    .issueaddr(issueaddr),
    .selected (issue_oprs)
  );

  assign pc      = issue_payload.pc;
  assign imm     = issue_payload.imm;
  assign rrftag  = issue_payload.rrftag;
  assign dstval  = issue_payload.dstval;
  assign src_a   = issue_payload.src_a;
  assign src_b   = issue_payload.src_b;
  assign alu_op  = issue_payload.alu_op;
  assign spectag = issue_payload.spectag;
  assign ex_src1 = issue_oprs.src1;
  assign ex_src2 = issue_oprs.src2;

endmodule

/* test/tb_rs_alu_props.svh */
`ifndef TB_RS_ALU_PROPS_SVH
`define TB_RS_ALU_PROPS_SVH

// Compared against the reference model in tb_rs_alu

assert property (@(posedge clk) $fell(reset) |-> (busyvec == '0 && ready == '0))
  else mismatch("busyvec/ready after reset", {$sampled(busyvec), $sampled(ready)}, '0);

assert property (@(posedge clk) disable iff (reset) busyvec === m_busy)
  else mismatch("busyvec", $sampled(busyvec), $sampled(m_busy));

assert property (@(posedge clk) disable iff (reset) ready === exp_ready)
  else mismatch("ready", $sampled(ready), $sampled(exp_ready));

// Issue outputs only matter for an occupied entry
assert property (@(posedge clk) disable iff (reset) m_busy[issueaddr] |-> iss_pay === exp_pay)
  else mismatch("issue payload", $sampled(iss_pay), $sampled(exp_pay));

assert property (@(posedge clk) disable iff (reset)
  m_busy[issueaddr] |-> ex_src1 === exp_op1.val)
  else mismatch("ex_src1", $sampled(ex_src1), $sampled(exp_op1.val));

assert property (@(posedge clk) disable iff (reset)
  m_busy[issueaddr] |-> ex_src2 === exp_op2.val)
  else mismatch("ex_src2", $sampled(ex_src2), $sampled(exp_op2.val));

`endif

/* test/tb_rs_alu.sv */
module tb_rs_alu
  import rs_alu_pkg::*;
();

  localparam int ENT_NUM      = 8;
  localparam int NUM_RESULT   = 5;
  localparam int ENT_SEL      = $clog2(ENT_NUM);
  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int N_PAIR       = 10;
  localparam int N_WAKE       = 6;
  localparam int N_MISS       = 6;
  localparam int STIM_CYCLES  = RESET_CYCLES + 3 * N_PAIR + 4 * N_WAKE + 6 * N_MISS + 3;

  logic               clk = 1'b0;
  logic               reset;
  logic               we1;
  logic               we2;
  logic [ENT_SEL-1:0] waddr1;
  logic [ENT_SEL-1:0] waddr2;
  alloc_t             a1;
  alloc_t             a2;
  logic               clearbusy;
  logic [ENT_SEL-1:0] issueaddr;
  logic               prmiss;
  spec_tag_t          specfixtag;
  data_t              exrslt [NUM_RESULT];
  rrf_tag_t           exdst [NUM_RESULT];
  logic               kill_spec [NUM_RESULT];
  logic [ENT_NUM-1:0] busyvec;
  logic [ENT_NUM-1:0] ready;
  rs_payload_t        iss_pay;
  data_t              ex_src1;
  data_t              ex_src2;
  integer             seed = 32'h55dd;

  // Reference model state
  logic [ENT_NUM-1:0] m_busy;
  rs_payload_t        m_pay [ENT_NUM];
  operand_t           m_op1 [ENT_NUM];
  operand_t           m_op2 [ENT_NUM];
  logic [ENT_NUM-1:0] exp_ready;
  rs_payload_t        exp_pay;
  operand_t           exp_op1;
  operand_t           exp_op2;

  always #(CLK_PERIOD / 2) clk = ~clk;

  rs_alu #(
    .ENT_NUM   (ENT_NUM),
    .NUM_RESULT(NUM_RESULT)
  ) i_dut (
    .clk       (clk),
    .reset     (reset),
    .we1       (we1),
    .waddr1    (waddr1),
    .wpc_1     (a1.payload.pc),
    .wimm_1    (a1.payload.imm),
    .wrrftag_1 (a1.payload.rrftag),
    .wdstval_1 (a1.payload.dstval),
    .wsrc_a_1  (a1.payload.src_a),
    .wsrc_b_1  (a1.payload.src_b),
    .walu_op_1 (a1.payload.alu_op),
    .wspectag_1(a1.payload.spectag),
    .wsrc1_1   (a1.src1.val),
    .wvalid1_1 (a1.src1.valid),
    .wsrc2_1   (a1.src2.val),
    .wvalid2_1 (a1.src2.valid),
    .we2       (we2),
    .waddr2    (waddr2),
    .wpc_2     (a2.payload.pc),
    .wimm_2    (a2.payload.imm),
    .wrrftag_2 (a2.payload.rrftag),
    .wdstval_2 (a2.payload.dstval),
    .wsrc_a_2  (a2.payload.src_a),
    .wsrc_b_2  (a2.payload.src_b),
    .walu_op_2 (a2.payload.alu_op),
    .wspectag_2(a2.payload.spectag),
    .wsrc1_2   (a2.src1.val),
    .wvalid1_2 (a2.src1.valid),
    .wsrc2_2   (a2.src2.val),
    .wvalid2_2 (a2.src2.valid),
    .clearbusy (clearbusy),
    .issueaddr (issueaddr),
    .prmiss    (prmiss),
    .specfixtag(specfixtag),
    .exrslt    (exrslt),
    .exdst     (exdst),
    .kill_spec (kill_spec),
    .busyvec   (busyvec),
    .ready     (ready),
    .pc        (iss_pay.pc),
    .imm       (iss_pay.imm),
    .rrftag    (iss_pay.rrftag),
    .dstval    (iss_pay.dstval),
    .src_a     (iss_pay.src_a),
    .src_b     (iss_pay.src_b),
    .alu_op    (iss_pay.alu_op),
    .spectag   (iss_pay.spectag),
    .ex_src1   (ex_src1),
    .ex_src2   (ex_src2)
  );

  // An operand not yet valid takes the data of any unkilled bus carrying its tag
  function automatic operand_t wake(operand_t opr);
    operand_t res;
    res = opr;
    for (int r = 0; r < NUM_RESULT; r++) begin
      if (!opr.valid && !kill_spec[r] && exdst[r] == opr.val[RRF_SEL-1:0]) begin
        res = '{valid: 1'b1, val: exrslt[r]};
      end
    end
    return res;
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      m_busy <= '0;
      for (int i = 0; i < ENT_NUM; i++) begin
        m_op1[i].valid <= 1'b0;
        m_op2[i].valid <= 1'b0;
      end
    end else begin
      for (int i = 0; i < ENT_NUM; i++) begin
        m_op1[i] <= wake(m_op1[i]);
        m_op2[i] <= wake(m_op2[i]);
      end
      if (prmiss) begin
        for (int i = 0; i < ENT_NUM; i++) begin
          if ((m_pay[i].spectag & specfixtag) != '0) m_busy[i] <= 1'b0;
        end
      end else begin
        if (we1) begin
          m_busy[waddr1] <= 1'b1;
          m_pay[waddr1]  <= a1.payload;
          m_op1[waddr1]  <= a1.src1;
          m_op2[waddr1]  <= a1.src2;
        end
        if (we2) begin
          m_busy[waddr2] <= 1'b1;
          m_pay[waddr2]  <= a2.payload;
          m_op1[waddr2]  <= a2.src1;
          m_op2[waddr2]  <= a2.src2;
        end
        if (clearbusy) m_busy[issueaddr] <= 1'b0;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < ENT_NUM; i++) begin
      exp_ready[i] = m_busy[i] & m_op1[i].valid & m_op2[i].valid;  // Stored flags only
    end
    exp_pay = m_pay[issueaddr];
    exp_op1 = wake(m_op1[issueaddr]);  // Bypass included
    exp_op2 = wake(m_op2[issueaddr]);
  end

  task automatic stop_run(string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic mismatch(string name, logic [127:0] got, logic [127:0] exp);
    stop_run($sformatf("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp));
  endtask

  task automatic rand_alloc(output alloc_t a, input logic v1, input logic v2);
    a.payload.pc      = $random(seed);
    a.payload.imm     = $random(seed);
    a.payload.rrftag  = rrf_tag_t'($random(seed));
    a.payload.dstval  = 1'($random(seed));
    a.payload.src_a   = src_sel_t'($random(seed));
    a.payload.src_b   = src_sel_t'($random(seed));
    a.payload.alu_op  = alu_op_t'($random(seed));
    a.payload.spectag = spec_tag_t'(1) << ($unsigned($random(seed)) % SPECTAG_LEN);
    a.src1 = '{valid: v1, val: $random(seed)};
    a.src2 = '{valid: v2, val: $random(seed)};
  endtask

  // Killed buses carry noise and wake nothing
  task automatic drive_idle();
    we1       = 1'b0;
    we2       = 1'b0;
    clearbusy = 1'b0;
    prmiss    = 1'b0;
    for (int r = 0; r < NUM_RESULT; r++) begin
      exrslt[r]    = $random(seed);
      exdst[r]     = rrf_tag_t'($random(seed));
      kill_spec[r] = 1'b1;
    end
  endtask

  task automatic next_cycle();
    @(negedge clk);
    drive_idle();
  endtask

  `include "tb_rs_alu_props.svh"

  initial begin
    int e1;
    int e2;
    int b;
    rrf_tag_t t;
    reset      = 1'b1;
    a1         = '0;
    a2         = '0;
    waddr1     = '0;
    waddr2     = '0;
    issueaddr  = '0;
    specfixtag = '0;
    drive_idle();
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    next_cycle();

    // Dual allocation, issue read and clear
    for (int k = 0; k < N_PAIR; k++) begin
      e1 = $unsigned($random(seed)) % ENT_NUM;
      e2 = (e1 + 1 + $unsigned($random(seed)) % (ENT_NUM - 1)) % ENT_NUM;
      next_cycle();
      rand_alloc(a1, 1'b1, 1'b1);
      rand_alloc(a2, 1'b1, 1'b1);
      we1       = 1'b1;
      we2       = 1'b1;
      waddr1    = ENT_SEL'(e1);
      waddr2    = ENT_SEL'(e2);
      issueaddr = ENT_SEL'(e1);
      next_cycle();
      clearbusy = 1'b1;
      next_cycle();
      clearbusy = 1'b1;
      issueaddr = ENT_SEL'(e2);
    end

    // Wakeup of src2 by a killed bus and then by a live one
    for (int k = 0; k < N_WAKE; k++) begin
      e1 = $unsigned($random(seed)) % ENT_NUM;
      b  = $unsigned($random(seed)) % NUM_RESULT;
      t  = rrf_tag_t'($random(seed));
      next_cycle();
      rand_alloc(a1, 1'b1, 1'b0);
      a1.src2.val[RRF_SEL-1:0] = t;
      we1       = 1'b1;
      waddr1    = ENT_SEL'(e1);
      issueaddr = ENT_SEL'(e1);
      next_cycle();
      exdst[b] = t;
      next_cycle();
      exdst[b]     = t;
      kill_spec[b] = 1'b0;
      next_cycle();
      clearbusy = 1'b1;
    end

    // Fill every entry, squash on a branch miss, then flush
    for (int k = 0; k < N_MISS; k++) begin
      for (int j = 0; j < ENT_NUM / 2; j++) begin
        next_cycle();
        rand_alloc(a1, 1'($random(seed)), 1'($random(seed)));
        rand_alloc(a2, 1'($random(seed)), 1'($random(seed)));
        we1       = 1'b1;
        we2       = 1'b1;
        waddr1    = ENT_SEL'(2 * j);
        waddr2    = ENT_SEL'(2 * j + 1);
        issueaddr = ENT_SEL'($random(seed));
      end
      next_cycle();
      rand_alloc(a1, 1'b1, 1'b1);
      we1        = 1'b1;  // Must be dropped
      waddr1     = ENT_SEL'($random(seed));
      issueaddr  = waddr1;
      prmiss     = 1'b1;
      specfixtag = spec_tag_t'($random(seed));
      next_cycle();
      prmiss     = 1'b1;
      specfixtag = '1;
    end

    next_cycle();
    next_cycle();
    $display("** PASS **");
    $finish;
  end

  initial begin
    #((STIM_CYCLES + 20) * CLK_PERIOD);
    stop_run("Timeout: the test sequence did not complete in time");
  end

endmodule

/* compile.f */
+incdir+test
source/rs_alu_pkg.sv
source/alloc_decode.sv
source/operand_wakeup.sv
source/rs_entry.sv
source/busy_tracker.sv
source/issue_read.sv
source/rs_alu.sv
test/tb_rs_alu.sv

/* Bender.yml */
package:
  name: rs_alu

sources:
  - source/rs_alu_pkg.sv
  - source/alloc_decode.sv
  - source/operand_wakeup.sv
  - source/rs_entry.sv
  - source/busy_tracker.sv
  - source/issue_read.sv
  - source/rs_alu.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_rs_alu.sv
